// File: rtl/ex_isa_pkg.sv
/*
 * Architectural widths, micro-op and functional unit encodings,
 * and the internal ALU function codes of the execute stage.
 */
package ex_isa_pkg;

    localparam int XLEN    = 32;                // Data width
    localparam int REG_AW  = 5;                 // Register address width
    localparam int UOP_W   = 5;                 // Micro-op width
    localparam int SHAMT_W = $clog2(XLEN);      // Shift amount bits

    // Logic unit sub-operations
    localparam logic [1:0] LOP_XOR = 2'd0;
    localparam logic [1:0] LOP_OR  = 2'd1;
    localparam logic [1:0] LOP_AND = 2'd2;

    // Only one unit is ever active, so binary encoded
    typedef enum logic [1:0] {
        FU_ALU = 2'd0,
        FU_LSU = 2'd1,
        FU_CFU = 2'd2,
        FU_CSR = 2'd3
    } ex_fu_e;

    typedef enum logic [UOP_W-1:0] {
        UOP_ADD   = 5'h00, UOP_SUB  = 5'h01, UOP_XOR   = 5'h02, // ALU
        UOP_OR    = 5'h03, UOP_AND  = 5'h04, UOP_SLL   = 5'h05,
        UOP_SRL   = 5'h06, UOP_SRA  = 5'h07, UOP_ROR   = 5'h08,
        UOP_ROL   = 5'h09, UOP_SLT  = 5'h0a, UOP_SLTU  = 5'h0b,
        UOP_BEQ   = 5'h10, UOP_BNE  = 5'h11, UOP_BLT   = 5'h12, // CFU
        UOP_BGE   = 5'h13, UOP_BLTU = 5'h14, UOP_BGEU  = 5'h15,
        UOP_JALI  = 5'h16, UOP_JALR = 5'h17,
        UOP_TAKEN = 5'h18, UOP_NOT_TAKEN = 5'h19,                // Resolved
        UOP_LSU_LOAD  = 5'h1c,                                  // LSU
        UOP_LSU_STORE = 5'h1d,
        UOP_CSR_OP    = 5'h1e                                   // CSR
    } ex_uop_e;

    typedef enum logic [2:0] {
        ALU_FN_ADD   = 3'd0,            // Sum of lhs and rhs
        ALU_FN_SUB   = 3'd1,            // Difference
        ALU_FN_LOGIC = 3'd2,            // xor / or / and
        ALU_FN_SHIFT = 3'd3,            // Shifts and rotates
        ALU_FN_CMP   = 3'd4             // Less-than, zero extended
    } alu_fn_e;

endpackage

// File: rtl/ex_pipe_pkg.sv
/*
 * Pipeline structs of the execute stage: stage 2 input item,
 * decoded ALU controls, stage 3 output item and forwarding data.
 */
package ex_pipe_pkg;

    typedef struct packed {
        logic [ex_isa_pkg::REG_AW-1:0] rd;      // Destination register
        logic [ex_isa_pkg::XLEN-1:0]   opr_a;   // Operand A
        logic [ex_isa_pkg::XLEN-1:0]   opr_b;   // Operand B
        logic [ex_isa_pkg::XLEN-1:0]   opr_c;   // Operand C
        ex_isa_pkg::ex_uop_e           uop;     // Micro-op
        ex_isa_pkg::ex_fu_e            fu;      // Functional unit
        logic                          trap;    // Raise a trap
        logic [1:0]                    size;    // Instruction size
        logic [31:0]                   instr;   // Instruction word
    } s2_instr_t;

    typedef struct packed {
        ex_isa_pkg::alu_fn_e fn;                // Result source
        logic                sub;               // Invert rhs, carry in
        logic [1:0]          lop;               // Logic sub-op
        logic                shl;               // Shift/rotate left
        logic                arith;             // Sign fill on right shift
        logic                rot;               // Rotate, not shift
        logic                cmp_u;             // Unsigned compare
    } alu_ctrl_t;

    typedef struct packed {
        logic [ex_isa_pkg::REG_AW-1:0] rd;
        logic [ex_isa_pkg::XLEN-1:0]   opr_a;   // Result / address / target
        logic [ex_isa_pkg::XLEN-1:0]   opr_b;   // Store data, CSR data, cause
        ex_isa_pkg::ex_uop_e           uop;     // Branches resolved
        ex_isa_pkg::ex_fu_e            fu;
        logic                          trap;
        logic [1:0]                    size;
        logic [31:0]                   instr;
    } s3_instr_t;

    typedef struct packed {
        logic [ex_isa_pkg::REG_AW-1:0] rd;      // Writeback destination
        logic [ex_isa_pkg::XLEN-1:0]   wdata;   // Value to forward
        logic                          load;    // Value not ready yet
        logic                          csr;     // CSR read pending
    } fwd_t;

endpackage

// File: rtl/ex_op_decode.sv
/*
 * Operation decode: maps functional unit and micro-op onto
 * ALU controls, ALU operands and the conditional branch kind.
 */
`timescale 1ns/1ps

module ex_op_decode (
    input  ex_pipe_pkg::s2_instr_t            i_s2,        // Stage 2 item
    output ex_pipe_pkg::alu_ctrl_t            o_alu_ctrl,  // ALU controls
    output logic [ex_isa_pkg::XLEN-1:0]       o_alu_lhs,   // Left operand
    output logic [ex_isa_pkg::XLEN-1:0]       o_alu_rhs,   // Right operand
    output ex_isa_pkg::ex_uop_e               o_cond_kind  // Branch to resolve
);
    import ex_isa_pkg::*;

    // LSU address, JALR target and compares all work on A and B
    assign o_alu_lhs = i_s2.opr_a;
    assign o_alu_rhs = i_s2.opr_b;

    always_comb begin
        o_alu_ctrl    = '0;
        o_alu_ctrl.fn = ALU_FN_ADD;                 // Default, address sum
        o_cond_kind   = UOP_NOT_TAKEN;              // No condition pending
        if (i_s2.fu == FU_ALU) begin
            case (i_s2.uop)
                UOP_SUB: begin
                    o_alu_ctrl.fn  = ALU_FN_SUB;
                    o_alu_ctrl.sub = 1'b1;
                end
                UOP_XOR, UOP_OR, UOP_AND: begin
                    o_alu_ctrl.fn  = ALU_FN_LOGIC;
                    o_alu_ctrl.lop = (i_s2.uop == UOP_XOR) ? LOP_XOR :
                                     (i_s2.uop == UOP_OR)  ? LOP_OR  : LOP_AND;
                end
                UOP_SLL, UOP_SRL, UOP_SRA, UOP_ROR, UOP_ROL: begin
                    o_alu_ctrl.fn    = ALU_FN_SHIFT;
                    o_alu_ctrl.shl   = (i_s2.uop == UOP_SLL) || (i_s2.uop == UOP_ROL);
                    o_alu_ctrl.arith = (i_s2.uop == UOP_SRA);
                    o_alu_ctrl.rot   = (i_s2.uop == UOP_ROR) || (i_s2.uop == UOP_ROL);
                end
                UOP_SLT, UOP_SLTU: begin
                    o_alu_ctrl.fn    = ALU_FN_CMP;
                    o_alu_ctrl.cmp_u = (i_s2.uop == UOP_SLTU);
                end
                default: ;                          // ADD
            endcase
        end else if (i_s2.fu == FU_CFU) begin
            case (i_s2.uop)
                UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU: begin
                    o_alu_ctrl.fn    = ALU_FN_CMP;  // Compare mode
                    o_alu_ctrl.cmp_u = (i_s2.uop == UOP_BLTU) || (i_s2.uop == UOP_BGEU);
                    o_cond_kind      = i_s2.uop;
                end
                default: ;                          // JALR uses the sum
            endcase
        end
    end

endmodule

// File: rtl/ex_alu.sv
/*
 * Base integer ALU: shared adder, bitwise logic,
 * barrel shifter / rotator and signed or unsigned comparator.
 */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pipe_pkg::alu_ctrl_t      i_ctrl,     // Decoded controls
    input  logic [ex_isa_pkg::XLEN-1:0] i_lhs,      // Left hand operand
    input  logic [ex_isa_pkg::XLEN-1:0] i_rhs,      // Right hand operand
    output logic [ex_isa_pkg::XLEN-1:0] o_result,   // Selected result
    output logic [ex_isa_pkg::XLEN-1:0] o_sum,      // Adder output
    output logic                        o_lt,       // lhs < rhs
    output logic                        o_eq        // lhs == rhs
);
    import ex_isa_pkg::*;

    logic [XLEN-1:0]    add_rhs;
    logic [XLEN-1:0]    logic_out;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    shf_src;
    logic [2*XLEN-1:0]  rot_cat;
    logic [XLEN-1:0]    shf_raw;
    logic [XLEN-1:0]    shf_out;

    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] x);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = x[XLEN-1-i];
        end
        return r;
    endfunction

    // ------------------------------------------------------------------------
    // Adder, shared by add, sub, load/store address and JALR target

    assign add_rhs = i_ctrl.sub ? ~i_rhs : i_rhs;               // Two's complement
    assign o_sum   = i_lhs + add_rhs + {{(XLEN-1){1'b0}}, i_ctrl.sub};

    always_comb begin
        case (i_ctrl.lop)
            LOP_XOR: logic_out = i_lhs ^ i_rhs;
            LOP_OR:  logic_out = i_lhs | i_rhs;
            default: logic_out = i_lhs & i_rhs;
        endcase
    end

    // ------------------------------------------------------------------------
    // Shifter, left ops done as right ops on bit reversed data

    assign shamt   = i_rhs[SHAMT_W-1:0];                        // Low 5 bits only
    assign shf_src = i_ctrl.shl ? bit_rev(i_lhs) : i_lhs;
    assign rot_cat = {shf_src, shf_src} >> shamt;               // Wraps low bits

    always_comb begin
        if (i_ctrl.rot) begin
            shf_raw = rot_cat[XLEN-1:0];
        end else if (i_ctrl.arith) begin
            shf_raw = $signed(shf_src) >>> shamt;
        end else begin
            shf_raw = shf_src >> shamt;
        end
    end

    assign shf_out = i_ctrl.shl ? bit_rev(shf_raw) : shf_raw;

    // Comparator, also drives branch resolution
    assign o_lt = i_ctrl.cmp_u ? (i_lhs < i_rhs) : ($signed(i_lhs) < $signed(i_rhs));
    assign o_eq = (i_lhs == i_rhs);

    always_comb begin
        case (i_ctrl.fn)
            ALU_FN_LOGIC: o_result = logic_out;
            ALU_FN_SHIFT: o_result = shf_out;
            ALU_FN_CMP:   o_result = {{(XLEN-1){1'b0}}, o_lt}; // SLT / SLTU
            default:      o_result = o_sum;                     // ADD / SUB
        endcase
    end

endmodule

// File: rtl/ex_result_select.sv
/*
 * Result selection: branch resolution, jump target, per-unit
 * operand A/B choice, trap cause and same-cycle forwarding.
 */
`timescale 1ns/1ps

module ex_result_select (
    input  ex_pipe_pkg::s2_instr_t      i_s2,           // Stage 2 item
    input  ex_isa_pkg::ex_uop_e         i_cond_kind,    // Branch to resolve
    input  logic [ex_isa_pkg::XLEN-1:0] i_alu_result,   // ALU result
    input  logic [ex_isa_pkg::XLEN-1:0] i_sum,          // Adder output
    input  logic                        i_lt,           // Compare result
    input  logic                        i_eq,
    output ex_pipe_pkg::s3_instr_t      o_next,         // Next stage 3 item
    output logic                        o_opra_ld,      // Load opr_a
    output logic                        o_oprb_ld,      // Load opr_b
    output ex_pipe_pkg::fwd_t           o_fwd           // Writeback forwarding
);
    import ex_isa_pkg::*;

    logic            is_cond;
    logic            taken;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] opr_a;
    logic            lsu_store;
    logic            fu_csr;

    // ------------------------------------------------------------------------
    // Branch resolution

    always_comb begin
        is_cond = 1'b1;
        case (i_cond_kind)
            UOP_BEQ:            taken = i_eq;
            UOP_BNE:            taken = !i_eq;
            UOP_BLT, UOP_BLTU:  taken = i_lt;   // Signedness set in decode
            UOP_BGE, UOP_BGEU:  taken = !i_lt;
            default: begin
                is_cond = 1'b0;
                taken   = 1'b0;
            end
        endcase
    end

    // Bit 0 cleared for both jump forms
    assign target = (i_s2.uop == UOP_JALR) ? {i_sum[XLEN-1:1], 1'b0} :
                                             {i_s2.opr_c[XLEN-1:1], 1'b0};

    // ------------------------------------------------------------------------
    // Operand selection

    always_comb begin
        case (i_s2.fu)
            FU_ALU:  opr_a = i_alu_result;
            FU_LSU:  opr_a = i_sum;             // Load / store address
            FU_CFU:  opr_a = target;
            default: opr_a = i_s2.opr_a;        // CSR passes through
        endcase
    end

    assign lsu_store = (i_s2.fu == FU_LSU) && (i_s2.uop == UOP_LSU_STORE);
    assign fu_csr    = (i_s2.fu == FU_CSR);

    assign o_next.rd    = i_s2.rd;
    assign o_next.opr_a = opr_a;
    assign o_next.opr_b = i_s2.trap ? {{(XLEN-REG_AW){1'b0}}, i_s2.rd} :  // Trap cause
                          (lsu_store || fu_csr) ? i_s2.opr_c : '0;
    assign o_next.uop   = is_cond ? (taken ? UOP_TAKEN : UOP_NOT_TAKEN) : i_s2.uop;
    assign o_next.fu    = i_s2.fu;
    assign o_next.trap  = i_s2.trap;
    assign o_next.size  = i_s2.size;
    assign o_next.instr = i_s2.instr;

    assign o_opra_ld = 1'b1;                    // Every unit yields opr_a
    assign o_oprb_ld = lsu_store || fu_csr || i_s2.trap;

    assign o_fwd.rd    = i_s2.rd;
    assign o_fwd.wdata = opr_a;
    assign o_fwd.load  = (i_s2.fu == FU_LSU) && (i_s2.uop == UOP_LSU_LOAD);
    assign o_fwd.csr   = fu_csr;

endmodule

// File: rtl/ex_stage_reg.sv
/*
 * Stage 3 pipeline register with valid/busy hold, flush,
 * and separately enabled operand A/B loads.
 */
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic                   g_clk,
    input  logic                   g_resetn,       // Sync, active low
    input  logic                   i_flush,        // Drop the stage contents
    input  logic                   i_valid,        // Stage 2 item valid
    input  ex_pipe_pkg::s3_instr_t i_next,         // Item to register
    input  logic                   i_opra_ld,      // opr_a load enable
    input  logic                   i_oprb_ld,      // opr_b load enable
    input  logic                   i_s3_busy,      // Stage 3 stalled
    output logic                   o_s2_busy,      // Back-pressure upstream
    output ex_pipe_pkg::s3_instr_t o_s3,           // Registered item
    output logic                   o_s3_valid
);

    logic take;                                     // Item enters register

    assign o_s2_busy = o_s3_valid && i_s3_busy;     // Full and not draining
    assign take      = i_valid && !o_s2_busy && !i_flush;

    // ------------------------------------------------------------------------
    // Valid bit

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_s3_valid <= 1'b0;
        end else if (i_flush) begin
            o_s3_valid <= 1'b0;
        end else if (!o_s2_busy) begin
            o_s3_valid <= i_valid;                  // Refill or empty out
        end
    end

    // Payload, held while stage 3 is busy
    always_ff @(posedge g_clk) begin
        if (take) begin
            o_s3.rd    <= i_next.rd;
            o_s3.uop   <= i_next.uop;
            o_s3.fu    <= i_next.fu;
            o_s3.trap  <= i_next.trap;
            o_s3.size  <= i_next.size;
            o_s3.instr <= i_next.instr;
        end
        if (take && i_opra_ld) begin
            o_s3.opr_a <= i_next.opr_a;
        end
        // opr_b keeps its last value unless the unit writes it
        if (take && i_oprb_ld) begin
            o_s3.opr_b <= i_next.opr_b;
        end
    end

endmodule

// File: rtl/ex_stage.sv
/*
 * Execute stage top level: decode, ALU, result select
 * and the stage 3 pipeline register.
 */
`timescale 1ns/1ps

module ex_stage (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  ex_pipe_pkg::s2_instr_t i_s2,           // Decoded instruction
    input  logic                   i_s2_valid,
    input  logic                   i_flush,
    input  logic                   i_s3_busy,
    output logic                   o_s2_busy,
    output ex_pipe_pkg::s3_instr_t o_s3,
    output logic                   o_s3_valid,
    output ex_pipe_pkg::fwd_t      o_fwd           // Same-cycle forwarding
);
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    alu_ctrl_t       alu_ctrl;
    logic [XLEN-1:0] alu_lhs;
    logic [XLEN-1:0] alu_rhs;
    ex_uop_e         cond_kind;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_sum;
    logic            alu_lt;
    logic            alu_eq;
    s3_instr_t       s3_next;
    logic            opra_ld;
    logic            oprb_ld;

    // ------------------------------------------------------------------------
    // Combinational datapath

    ex_op_decode u_decode (
        .i_s2        (i_s2),
        .o_alu_ctrl  (alu_ctrl),
        .o_alu_lhs   (alu_lhs),
        .o_alu_rhs   (alu_rhs),
        .o_cond_kind (cond_kind)
    );

    ex_alu u_alu (
        .i_ctrl   (alu_ctrl),
        .i_lhs    (alu_lhs),
        .i_rhs    (alu_rhs),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    ex_result_select u_select (
        .i_s2         (i_s2),
        .i_cond_kind  (cond_kind),
        .i_alu_result (alu_result),
        .i_sum        (alu_sum),
        .i_lt         (alu_lt),
        .i_eq         (alu_eq),
        .o_next       (s3_next),
        .o_opra_ld    (opra_ld),
        .o_oprb_ld    (oprb_ld),
        .o_fwd        (o_fwd)
    );

    // Single register stage into stage 3
    ex_stage_reg u_reg (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_flush    (i_flush),
        .i_valid    (i_s2_valid),
        .i_next     (s3_next),
        .i_opra_ld  (opra_ld),
        .i_oprb_ld  (oprb_ld),
        .i_s3_busy  (i_s3_busy),
        .o_s2_busy  (o_s2_busy),
        .o_s3       (o_s3),
        .o_s3_valid (o_s3_valid)
    );

endmodule

// File: dv/ex_stage_assert.sv
/*
 * Bound checker for the execute stage: reference model of each
 * accepted item, stage 3 contents, back-pressure, flush and reset.
 */
`timescale 1ns/1ps

module ex_stage_assert (
    input logic                   g_clk,
    input logic                   g_resetn,
    input ex_pipe_pkg::s2_instr_t i_s2,
    input logic                   i_s2_valid,
    input logic                   i_flush,
    input logic                   i_s3_busy,
    input logic                   o_s2_busy,
    input ex_pipe_pkg::s3_instr_t o_s3,
    input logic                   o_s3_valid
);
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    s3_instr_t exp_s3;                              // Expected stage 3 item
    logic      new_item = 1'b0;                     // Item entered on last edge
    logic      b_known  = 1'b0;                     // exp_s3.opr_b defined
    logic      accept;
    int        fail_cnt = 0;                        // Summed by the testbench

    function automatic logic cond_holds(input s2_instr_t s);
        case (s.uop)
            UOP_BEQ:  return s.opr_a == s.opr_b;
            UOP_BNE:  return s.opr_a != s.opr_b;
            UOP_BLT:  return $signed(s.opr_a) < $signed(s.opr_b);
            UOP_BGE:  return $signed(s.opr_a) >= $signed(s.opr_b);
            UOP_BLTU: return s.opr_a < s.opr_b;
            default:  return s.opr_a >= s.opr_b;    // BGEU
        endcase
    endfunction

    function automatic s3_instr_t model_item(input s2_instr_t s, input logic [XLEN-1:0] old_b);
        s3_instr_t  m;
        logic [4:0] n;
        n       = s.opr_b[4:0];                     // Shift amount
        m.rd    = s.rd;
        m.opr_b = old_b;                            // Kept unless written
        m.uop   = s.uop;
        m.fu    = s.fu;
        m.trap  = s.trap;
        m.size  = s.size;
        m.instr = s.instr;
        case (s.uop)
            UOP_ADD, UOP_LSU_LOAD, UOP_LSU_STORE: m.opr_a = s.opr_a + s.opr_b;
            UOP_SUB:    m.opr_a = s.opr_a - s.opr_b;
            UOP_XOR:    m.opr_a = s.opr_a ^ s.opr_b;
            UOP_OR:     m.opr_a = s.opr_a | s.opr_b;
            UOP_AND:    m.opr_a = s.opr_a & s.opr_b;
            UOP_SLL:    m.opr_a = s.opr_a << n;
            UOP_SRL:    m.opr_a = s.opr_a >> n;
            UOP_SRA:    m.opr_a = $signed(s.opr_a) >>> n;
            UOP_ROR:    m.opr_a = (s.opr_a >> n) | (s.opr_a << (XLEN - n));
            UOP_ROL:    m.opr_a = (s.opr_a << n) | (s.opr_a >> (XLEN - n));
            UOP_SLT:    m.opr_a = {{(XLEN-1){1'b0}}, $signed(s.opr_a) < $signed(s.opr_b)};
            UOP_SLTU:   m.opr_a = {{(XLEN-1){1'b0}}, s.opr_a < s.opr_b};
            UOP_JALR:   m.opr_a = (s.opr_a + s.opr_b) & ~32'h1;
            UOP_CSR_OP: m.opr_a = s.opr_a;
            default:    m.opr_a = s.opr_c & ~32'h1;     // JALI, branch target
        endcase
        if (s.uop inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU}) begin
            m.uop = cond_holds(s) ? UOP_TAKEN : UOP_NOT_TAKEN;
        end
        if (s.trap) begin
            m.opr_b = {{(XLEN-REG_AW){1'b0}}, s.rd};    // Trap cause
        end else if (s.uop == UOP_LSU_STORE || s.uop == UOP_CSR_OP) begin
            m.opr_b = s.opr_c;                          // Store or CSR data
        end
        return m;
    endfunction

    function automatic string fu_name(input ex_fu_e fu);
        case (fu)
            FU_ALU:  return "alu";
            FU_LSU:  return "lsu";
            FU_CFU:  return "branch";
            default: return "csr";
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Reference copy of each accepted item

    assign accept = i_s2_valid && !o_s2_busy && !i_flush;

    always @(posedge g_clk) begin
        new_item <= accept && g_resetn;
        if (accept) begin
            exp_s3  <= model_item(i_s2, exp_s3.opr_b);
            b_known <= b_known || i_s2.trap || i_s2.uop == UOP_LSU_STORE ||
                       i_s2.uop == UOP_CSR_OP;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 3 checks

    a_opr_a: assert property (@(posedge g_clk) disable iff (!g_resetn)
        new_item |-> o_s3.opr_a == exp_s3.opr_a)
        else begin
            fail_cnt++;
            $error("ERROR %s opr_a: expected %h, actual %h", fu_name($sampled(exp_s3.fu)),
                   $sampled(exp_s3.opr_a), $sampled(o_s3.opr_a));
        end

    a_opr_b: assert property (@(posedge g_clk) disable iff (!g_resetn)
        new_item && b_known |-> o_s3.opr_b == exp_s3.opr_b)
        else begin
            fail_cnt++;
            $error("ERROR %s opr_b: expected %h, actual %h", fu_name($sampled(exp_s3.fu)),
                   $sampled(exp_s3.opr_b), $sampled(o_s3.opr_b));
        end

    a_uop: assert property (@(posedge g_clk) disable iff (!g_resetn)
        new_item |-> o_s3.uop == exp_s3.uop)
        else begin
            fail_cnt++;
            $error("ERROR %s uop: expected %h, actual %h", fu_name($sampled(exp_s3.fu)),
                   $sampled(exp_s3.uop), $sampled(o_s3.uop));
        end

    a_fields: assert property (@(posedge g_clk) disable iff (!g_resetn)
        new_item |-> o_s3_valid && o_s3.rd == exp_s3.rd && o_s3.fu == exp_s3.fu &&
                     o_s3.trap == exp_s3.trap && o_s3.size == exp_s3.size &&
                     o_s3.instr == exp_s3.instr)
        else begin
            fail_cnt++;
            $error("Accepted item did not reach stage 3 one cycle later with its fields intact");
        end

    // Back-pressure holds the stage and stalls stage 2
    a_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_s3_valid && i_s3_busy && !i_flush |=> o_s3_valid && $stable(o_s3))
        else begin
            fail_cnt++;
            $error("Stage 3 item changed while stage 3 was busy");
        end

    a_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        o_s3_valid && i_s3_busy |-> o_s2_busy)
        else begin
            fail_cnt++;
            $error("o_s2_busy low while stage 3 was full and busy");
        end

    a_flush: assert property (@(posedge g_clk) i_flush |=> !o_s3_valid)
        else begin
            fail_cnt++;
            $error("o_s3_valid high on the cycle after a flush");
        end

    a_reset: assert property (@(posedge g_clk) !g_resetn |=> !o_s3_valid)
        else begin
            fail_cnt++;
            $error("o_s3_valid high during reset");
        end

endmodule

bind ex_stage ex_stage_assert u_check (.*);

// File: dv/tb_ex_stage.sv
/*
 * Testbench for the execute stage: clock, reset, LCG driven
 * stimulus for every unit, forwarding checks and the closing line.
 */
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int WAIT_LIMIT = 64;                 // Cycles before a wait gives up

    logic            g_clk;
    logic            g_resetn;
    s2_instr_t       s2_in;
    logic            s2_valid;
    logic            flush;
    logic            s3_busy;
    logic            s2_busy;
    s3_instr_t       s3_out;
    logic            s3_valid;
    fwd_t            fwd;
    logic [31:0]     lcg_state = 32'h7006;          // LCG seed
    logic            bp_mode;                       // Random stage 3 stalls
    logic            fwd_pend  = 1'b0;              // Forwarded value to compare
    logic [XLEN-1:0] fwd_wdata = '0;
    int              tb_errors = 0;
    int              timeouts  = 0;
    int              total;

    ex_uop_e alu_ops[12] = '{UOP_ADD, UOP_SUB, UOP_XOR, UOP_OR, UOP_AND, UOP_SLL,
                             UOP_SRL, UOP_SRA, UOP_ROR, UOP_ROL, UOP_SLT, UOP_SLTU};
    ex_uop_e cfu_ops[8]  = '{UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE,
                             UOP_BLTU, UOP_BGEU, UOP_JALI, UOP_JALR};

    ex_stage dut (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .i_s2       (s2_in),
        .i_s2_valid (s2_valid),
        .i_flush    (flush),
        .i_s3_busy  (s3_busy),
        .o_s2_busy  (s2_busy),
        .o_s3       (s3_out),
        .o_s3_valid (s3_valid),
        .o_fwd      (fwd)
    );

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;                 // 20 ns period
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic s2_instr_t rand_item(input ex_fu_e fu, input ex_uop_e uop);
        s2_instr_t   s;
        logic [31:0] r;
        r       = next_rand();
        s.rd    = r[31:27];
        s.size  = r[26:25];
        s.trap  = (r[24:22] == 3'd0);               // About one in eight
        s.opr_a = next_rand();
        s.opr_b = (r[21:19] == 3'd0) ? s.opr_a : next_rand();  // Equal operands now and then
        s.opr_c = next_rand();
        s.instr = next_rand();
        s.uop   = uop;
        s.fu    = fu;
        return s;
    endfunction

    function automatic s2_instr_t mixed_item();
        logic [31:0] r;
        r = next_rand();
        case (r[31:30])
            2'd0:    return rand_item(FU_ALU, alu_ops[r[29:26] % 12]);
            2'd1:    return rand_item(FU_CFU, cfu_ops[r[29:27]]);
            2'd2:    return rand_item(FU_LSU, r[29] ? UOP_LSU_STORE : UOP_LSU_LOAD);
            default: return rand_item(FU_CSR, UOP_CSR_OP);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            tb_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Drive one item, then wait until the next edge accepts it
    task automatic send_item(input s2_instr_t item);
        logic [31:0] r;
        int          waited;
        waited = 0;
        r      = next_rand();
        @(posedge g_clk);
        s2_in    <= item;
        s2_valid <= 1'b1;
        s3_busy  <= bp_mode && r[31];
        @(negedge g_clk);
        while (s2_busy && waited < WAIT_LIMIT) begin
            r = next_rand();
            @(posedge g_clk);
            s3_busy <= bp_mode && r[31];
            @(negedge g_clk);
            waited++;
        end
        if (s2_busy) begin
            timeouts++;
            $display("Timeout: stage 2 item was never accepted");
        end
    endtask

    task automatic go_idle();
        @(posedge g_clk);
        s2_valid <= 1'b0;
        s3_busy  <= 1'b0;
        flush    <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Forwarding checks, sampled mid cycle

    always @(negedge g_clk) begin
        if (fwd_pend) begin
            check_value("fwd_wdata", fwd_wdata, s3_out.opr_a);
        end
        fwd_pend = 1'b0;
        if (g_resetn && s2_valid) begin
            check_value("fwd_rd", 32'(s2_in.rd), 32'(fwd.rd));
            check_value("fwd_load", 32'(s2_in.fu == FU_LSU && s2_in.uop == UOP_LSU_LOAD),
                        32'(fwd.load));
            check_value("fwd_csr", 32'(s2_in.fu == FU_CSR), 32'(fwd.csr));
            if (!s2_busy && !flush) begin           // Accepted on the coming edge
                fwd_pend  = 1'b1;
                fwd_wdata = fwd.wdata;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus

    initial begin
        s2_in    = '0;
        s2_valid = 1'b0;
        flush    = 1'b0;
        s3_busy  = 1'b0;
        g_resetn = 1'b0;
        bp_mode  = 1'b0;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;

        send_item(rand_item(FU_CSR, UOP_CSR_OP));   // Defines opr_b first
        foreach (alu_ops[i]) begin
            repeat (12) send_item(rand_item(FU_ALU, alu_ops[i]));
        end
        foreach (cfu_ops[i]) begin
            repeat (12) send_item(rand_item(FU_CFU, cfu_ops[i]));
        end
        repeat (12) send_item(rand_item(FU_LSU, UOP_LSU_LOAD));
        repeat (12) send_item(rand_item(FU_LSU, UOP_LSU_STORE));
        repeat (12) send_item(rand_item(FU_CSR, UOP_CSR_OP));

        bp_mode = 1'b1;                             // Mixed traffic with stalls
        repeat (300) send_item(mixed_item());
        bp_mode = 1'b0;
        go_idle();

        // Flush with a valid item pending, which must be dropped
        send_item(rand_item(FU_ALU, UOP_ADD));
        @(posedge g_clk);
        s2_in <= rand_item(FU_ALU, UOP_SUB);
        flush <= 1'b1;
        go_idle();

        // Reset in mid run with a valid item still offered, then traffic again
        send_item(rand_item(FU_ALU, UOP_XOR));
        @(posedge g_clk);
        s2_in    <= rand_item(FU_ALU, UOP_AND);
        g_resetn <= 1'b0;
        repeat (3) @(posedge g_clk);
        s2_valid <= 1'b0;
        g_resetn <= 1'b1;
        repeat (20) send_item(mixed_item());
        go_idle();
        repeat (4) @(posedge g_clk);

        total = tb_errors + dut.u_check.fail_cnt + timeouts;
        $display("Done: %0d testbench errors, %0d assertion failures, %0d timeouts",
                 tb_errors, dut.u_check.fail_cnt, timeouts);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: files.f
rtl/ex_isa_pkg.sv
rtl/ex_pipe_pkg.sv
rtl/ex_op_decode.sv
rtl/ex_alu.sv
rtl/ex_result_select.sv
rtl/ex_stage_reg.sv
rtl/ex_stage.sv
dv/ex_stage_assert.sv
dv/tb_ex_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ex_stage \
    -f files.f -o sim_ex_stage

# Raise the error limit so the testbench reaches its closing line
./obj_dir/sim_ex_stage +verilator+error+limit+1000 | tee sim.log

if grep -q "^No errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
